//--- logic/gbe_defines.svh
`ifndef GBE_DEFINES_SVH
`define GBE_DEFINES_SVH

// cpu address windows
`define GBE_REG_BASE        32'h0000_0000
`define GBE_TXBUF_BASE      32'h0000_1000
`define GBE_RXBUF_BASE      32'h0000_2000
`define GBE_ARP_BASE        32'h0000_3000
`define GBE_WIN_SIZE        32'h0000_0800

// register word index, bus address bits 5:2
`define GBE_REG_MAC_HI      4'd0
`define GBE_REG_MAC_LO      4'd1
`define GBE_REG_GATEWAY     4'd3
`define GBE_REG_IP          4'd4
`define GBE_REG_SIZES       4'd6
`define GBE_REG_PORTS       4'd8
`define GBE_REG_XAUI_STATUS 4'd9
`define GBE_REG_PHY         4'd10
`define GBE_REG_MC_IP       4'd12
`define GBE_REG_MC_MASK     4'd13

// local register reset values
`define GBE_DEF_MAC         48'h0200_0a0b_0c0d
`define GBE_DEF_IP          32'hc0a8_0102
`define GBE_DEF_PORT        16'h2710
`define GBE_DEF_GATEWAY     8'd1
`define GBE_DEF_ENABLE      1'b0
`define GBE_DEF_MC_IP       32'h0000_0000
`define GBE_DEF_MC_MASK     32'h0000_0000
`define GBE_DEF_RXEQMIX     3'b111
`define GBE_DEF_PREEMPH     4'b0100
`define GBE_DEF_POSTEMPH    5'b00000
`define GBE_DEF_DIFFCTRL    4'b1010

// buffer geometry, one 64-bit word per entry
`define GBE_BUF_DEPTH       256
`define GBE_BUF_AW          8

`endif

//--- logic/gbe_pkg.sv
package gbe_pkg;

  typedef struct packed {
    logic [7:0] rsvd_hi;
    logic [7:0] tx_size;
    logic [7:0] rsvd_lo;
    logic [7:0] rx_size;
  } sizes_t;

  typedef struct packed {
    logic [6:0]  rsvd_hi;
    logic        soft_reset;
    logic [6:0]  rsvd_lo;
    logic        enable;
    logic [15:0] port;
  } ports_t;

  typedef struct packed {
    logic [3:0] rsvd3;
    logic [3:0] diffctrl;
    logic [3:0] rsvd2;
    logic [3:0] preemph;
    logic [2:0] rsvd1;
    logic [4:0] postemph;
    logic [4:0] rsvd0;
    logic [2:0] rxeqmix;
  } phy_t;

  // one register word, viewed per register layout
  typedef union packed {
    logic [31:0] raw;
    sizes_t      sizes;
    ports_t      ports;
    phy_t        phy;
  } reg_word_u;

endpackage

//--- logic/cpu_mem_if.sv
`timescale 1ns/1ps
`include "gbe_defines.svh"

// one ram port, rd_data valid the clock after addr
interface cpu_mem_if #(
  parameter int DATA_W = 64
);
  logic [`GBE_BUF_AW-1:0] addr;
  logic [DATA_W-1:0]      wr_data;
  logic [DATA_W-1:0]      rd_data;
  logic                   wr_en;

  modport master (
    output addr,
    output wr_data,
    output wr_en,
    input  rd_data
  );

  modport mem (
    input  addr,
    input  wr_data,
    input  wr_en,
    output rd_data
  );
endinterface

//--- logic/dual_port_ram.sv
`timescale 1ns/1ps

module dual_port_ram #(
  parameter int DATA_W = 64,
  parameter int DEPTH  = 256
) (
  input  logic     wb_clk_i,
  cpu_mem_if.mem   a,
  cpu_mem_if.mem   b
);

  logic [DATA_W-1:0] mem_q [DEPTH];

  // both ports read the old word, port b wins a write collision
  always_ff @(posedge wb_clk_i) begin
    a.rd_data <= mem_q[a.addr];
    b.rd_data <= mem_q[b.addr];
    if (a.wr_en) begin
      mem_q[a.addr] <= a.wr_data;
    end
    if (b.wr_en) begin
      mem_q[b.addr] <= b.wr_data;
    end
  end

endmodule

//--- logic/wb_attach.sv
`timescale 1ns/1ps
`include "gbe_defines.svh"

module wb_attach (
  input  logic        wb_clk_i,
  input  logic        wb_rst_i,
  input  logic [31:0] wb_adr_i,
  input  logic [31:0] wb_dat_i,
  input  logic [3:0]  wb_sel_i,
  input  logic        wb_we_i,
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  output logic [31:0] wb_dat_o,
  output logic        wb_ack_o,
  cpu_mem_if.master   tx_mem,
  cpu_mem_if.master   rx_mem,
  cpu_mem_if.master   arp_mem,
  output logic [7:0]  cpu_tx_size_o,
  output logic        cpu_tx_ready_o,
  output logic        cpu_rx_ack_o,
  input  logic        cpu_tx_done_i,
  input  logic [7:0]  cpu_rx_size_i,
  input  logic [7:0]  xaui_status_i,
  input  logic        soft_reset_ack_i,
  output logic        local_enable_o,
  output logic [47:0] local_mac_o,
  output logic [31:0] local_ip_o,
  output logic [15:0] local_port_o,
  output logic [7:0]  local_gateway_o,
  output logic [31:0] local_mc_ip_o,
  output logic [31:0] local_mc_mask_o,
  output logic        soft_reset_o,
  output logic [2:0]  mgt_rxeqmix_o,
  output logic [3:0]  mgt_txpreemph_o,
  output logic [4:0]  mgt_txpostemph_o,
  output logic [3:0]  mgt_txdiffctrl_o
);
  import gbe_pkg::*;

  localparam logic [1:0] SRC_REG = 2'd0;
  localparam logic [1:0] SRC_TX  = 2'd1;
  localparam logic [1:0] SRC_RX  = 2'd2;
  localparam logic [1:0] SRC_ARP = 2'd3;

  logic        ack_q;
  logic        tx_wr_q;
  logic        arp_wr_q;
  logic        tx_we_q;
  logic        arp_we_q;
  logic [1:0]  rd_src_q;
  logic [3:0]  reg_idx_q;
  logic [63:0] wr_data_q;

  logic [47:0] mac_q;
  logic [31:0] ip_q;
  logic [7:0]  gateway_q;
  logic [15:0] port_q;
  logic        enable_q;
  logic [31:0] mc_ip_q;
  logic [31:0] mc_mask_q;
  logic        soft_reset_q;
  logic [2:0]  rxeqmix_q;
  logic [3:0]  preemph_q;
  logic [4:0]  postemph_q;
  logic [3:0]  diffctrl_q;
  logic [7:0]  tx_size_q;
  logic        tx_ready_q;
  logic        rx_ack_q;

  logic        wr_pend;
  logic        trans;
  logic        reg_sel;
  logic        tx_sel;
  logic        rx_sel;
  logic        arp_sel;
  reg_word_u   wr_w;
  reg_word_u   rd_w;
  logic [31:0] tx_half;
  logic [31:0] rx_half;
  logic [31:0] arp_half;
  logic [31:0] bus_rd;

  function automatic logic in_window(input logic [31:0] adr, input logic [31:0] base);
    in_window = (adr >= base) && (adr < base + `GBE_WIN_SIZE);
  endfunction

  function automatic logic [31:0] lane_merge(input logic [31:0] old_w,
                                             input logic [31:0] new_w,
                                             input logic [3:0]  sel);
    logic [31:0] res;
    res = old_w;
    for (int i = 0; i < 4; i++) begin
      if (sel[i]) begin
        res[8*i +: 8] = new_w[8*i +: 8];
      end
    end
    return res;
  endfunction

  // no new strobe while a memory write is pending
  assign wr_pend = tx_wr_q | arp_wr_q;
  assign trans   = wb_cyc_i && wb_stb_i && !ack_q && !wr_pend;
  assign reg_sel = trans && in_window(wb_adr_i, `GBE_REG_BASE);
  assign tx_sel  = trans && in_window(wb_adr_i, `GBE_TXBUF_BASE);
  assign rx_sel  = trans && in_window(wb_adr_i, `GBE_RXBUF_BASE);
  assign arp_sel = trans && in_window(wb_adr_i, `GBE_ARP_BASE);
  assign wr_w    = reg_word_u'(wb_dat_i);

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      ack_q     <= 1'b0;
      tx_wr_q   <= 1'b0;
      arp_wr_q  <= 1'b0;
      rd_src_q  <= SRC_REG;
      reg_idx_q <= 4'd0;
    end else begin
      ack_q    <= wr_pend;
      tx_wr_q  <= tx_sel && wb_we_i;
      arp_wr_q <= arp_sel && wb_we_i;
      // tx and arp writes take the extra cycle for the merge
      if (reg_sel || rx_sel || ((tx_sel || arp_sel) && !wb_we_i)) begin
        ack_q <= 1'b1;
      end
      if (reg_sel) begin
        rd_src_q  <= SRC_REG;
        reg_idx_q <= wb_adr_i[5:2];
      end
      if (tx_sel) begin
        rd_src_q <= SRC_TX;
      end
      if (rx_sel) begin
        rd_src_q <= SRC_RX;
      end
      if (arp_sel) begin
        rd_src_q <= SRC_ARP;
      end
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      mac_q        <= `GBE_DEF_MAC;
      ip_q         <= `GBE_DEF_IP;
      gateway_q    <= `GBE_DEF_GATEWAY;
      port_q       <= `GBE_DEF_PORT;
      enable_q     <= `GBE_DEF_ENABLE;
      mc_ip_q      <= `GBE_DEF_MC_IP;
      mc_mask_q    <= `GBE_DEF_MC_MASK;
      rxeqmix_q    <= `GBE_DEF_RXEQMIX;
      preemph_q    <= `GBE_DEF_PREEMPH;
      postemph_q   <= `GBE_DEF_POSTEMPH;
      diffctrl_q   <= `GBE_DEF_DIFFCTRL;
      soft_reset_q <= 1'b0;
      tx_size_q    <= 8'd0;
      tx_ready_q   <= 1'b0;
      rx_ack_q     <= 1'b0;
    end else begin
      if (cpu_tx_done_i) begin
        tx_size_q  <= 8'd0;
        tx_ready_q <= 1'b0;
      end
      // loopback has dropped the rx frame
      if (cpu_rx_size_i == 8'd0) begin
        rx_ack_q <= 1'b0;
      end
      if (soft_reset_ack_i) begin
        soft_reset_q <= 1'b0;
      end
      if (reg_sel && wb_we_i) begin
        case (wb_adr_i[5:2])
          `GBE_REG_MAC_HI: begin
            if (wb_sel_i[0]) mac_q[39:32] <= wb_dat_i[7:0];
            if (wb_sel_i[1]) mac_q[47:40] <= wb_dat_i[15:8];
          end
          `GBE_REG_MAC_LO: mac_q[31:0] <= lane_merge(mac_q[31:0], wb_dat_i, wb_sel_i);
          `GBE_REG_GATEWAY: begin
            if (wb_sel_i[0]) gateway_q <= wb_dat_i[7:0];
          end
          `GBE_REG_IP: ip_q <= lane_merge(ip_q, wb_dat_i, wb_sel_i);
          `GBE_REG_SIZES: begin
            if (wb_sel_i[0] && wr_w.sizes.rx_size == 8'd0) rx_ack_q <= 1'b1;
            if (wb_sel_i[2]) begin
              tx_size_q  <= wr_w.sizes.tx_size;
              tx_ready_q <= 1'b1;
            end
          end
          `GBE_REG_PORTS: begin
            if (wb_sel_i[0]) port_q[7:0]  <= wr_w.ports.port[7:0];
            if (wb_sel_i[1]) port_q[15:8] <= wr_w.ports.port[15:8];
            if (wb_sel_i[2]) enable_q     <= wr_w.ports.enable;
            if (wb_sel_i[3] && wr_w.ports.soft_reset) soft_reset_q <= 1'b1;
          end
          `GBE_REG_PHY: begin
            if (wb_sel_i[0]) rxeqmix_q  <= wr_w.phy.rxeqmix;
            if (wb_sel_i[1]) postemph_q <= wr_w.phy.postemph;
            if (wb_sel_i[2]) preemph_q  <= wr_w.phy.preemph;
            if (wb_sel_i[3]) diffctrl_q <= wr_w.phy.diffctrl;
          end
          `GBE_REG_MC_IP:   mc_ip_q   <= lane_merge(mc_ip_q, wb_dat_i, wb_sel_i);
          `GBE_REG_MC_MASK: mc_mask_q <= lane_merge(mc_mask_q, wb_dat_i, wb_sel_i);
          default: begin
          end
        endcase
      end
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      tx_we_q  <= 1'b0;
      arp_we_q <= 1'b0;
    end else begin
      tx_we_q  <= tx_wr_q;
      arp_we_q <= arp_wr_q;
    end
  end

  // merge bus word into the old memory word, addr bit 2 picks the low half
  always_ff @(posedge wb_clk_i) begin
    if (tx_wr_q) begin
      if (wb_adr_i[2]) begin
        wr_data_q <= {tx_mem.rd_data[63:32],
                      lane_merge(tx_mem.rd_data[31:0], wb_dat_i, wb_sel_i)};
      end else begin
        wr_data_q <= {lane_merge(tx_mem.rd_data[63:32], wb_dat_i, wb_sel_i),
                      tx_mem.rd_data[31:0]};
      end
    end else if (arp_wr_q) begin
      if (wb_adr_i[2]) begin
        wr_data_q <= {16'd0, arp_mem.rd_data[47:32], wb_dat_i};
      end else begin
        wr_data_q <= {16'd0, wb_dat_i[15:0], arp_mem.rd_data[31:0]};
      end
    end
  end

  assign tx_mem.addr     = wb_adr_i[`GBE_BUF_AW+2:3];
  assign tx_mem.wr_data  = wr_data_q;
  assign tx_mem.wr_en    = tx_we_q;
  assign arp_mem.addr    = wb_adr_i[`GBE_BUF_AW+2:3];
  assign arp_mem.wr_data = wr_data_q[47:0];
  assign arp_mem.wr_en   = arp_we_q;
  // rx buffer is read only from the bus
  assign rx_mem.addr     = wb_adr_i[`GBE_BUF_AW+2:3];
  assign rx_mem.wr_data  = 64'd0;
  assign rx_mem.wr_en    = 1'b0;

  always_comb begin
    rd_w = '0;
    case (reg_idx_q)
      `GBE_REG_MAC_HI:      rd_w.raw = {16'd0, mac_q[47:32]};
      `GBE_REG_MAC_LO:      rd_w.raw = mac_q[31:0];
      `GBE_REG_GATEWAY:     rd_w.raw = {24'd0, gateway_q};
      `GBE_REG_IP:          rd_w.raw = ip_q;
      `GBE_REG_SIZES: begin
        rd_w.sizes.tx_size = tx_size_q;
        rd_w.sizes.rx_size = rx_ack_q ? 8'd0 : cpu_rx_size_i;
      end
      `GBE_REG_PORTS: begin
        rd_w.ports.soft_reset = soft_reset_q;
        rd_w.ports.enable     = enable_q;
        rd_w.ports.port       = port_q;
      end
      `GBE_REG_XAUI_STATUS: rd_w.raw = {24'd0, xaui_status_i};
      `GBE_REG_PHY: begin
        rd_w.phy.diffctrl = diffctrl_q;
        rd_w.phy.preemph  = preemph_q;
        rd_w.phy.postemph = postemph_q;
        rd_w.phy.rxeqmix  = rxeqmix_q;
      end
      `GBE_REG_MC_IP:       rd_w.raw = mc_ip_q;
      `GBE_REG_MC_MASK:     rd_w.raw = mc_mask_q;
      default:              rd_w.raw = 32'd0;
    endcase
  end

  assign tx_half  = wb_adr_i[2] ? tx_mem.rd_data[31:0] : tx_mem.rd_data[63:32];
  assign rx_half  = wb_adr_i[2] ? rx_mem.rd_data[31:0] : rx_mem.rd_data[63:32];
  assign arp_half = wb_adr_i[2] ? arp_mem.rd_data[31:0] : {16'd0, arp_mem.rd_data[47:32]};

  always_comb begin
    case (rd_src_q)
      SRC_TX:  bus_rd = tx_half;
      SRC_RX:  bus_rd = rx_half;
      SRC_ARP: bus_rd = arp_half;
      default: bus_rd = rd_w.raw;
    endcase
  end

  assign wb_dat_o = ack_q ? bus_rd : 32'd0;
  assign wb_ack_o = ack_q;

  assign cpu_tx_size_o    = tx_size_q;
  assign cpu_tx_ready_o   = tx_ready_q;
  assign cpu_rx_ack_o     = rx_ack_q;
  assign local_enable_o   = enable_q;
  assign local_mac_o      = mac_q;
  assign local_ip_o       = ip_q;
  assign local_port_o     = port_q;
  assign local_gateway_o  = gateway_q;
  assign local_mc_ip_o    = mc_ip_q;
  assign local_mc_mask_o  = mc_mask_q;
  assign soft_reset_o     = soft_reset_q;
  assign mgt_rxeqmix_o    = rxeqmix_q;
  assign mgt_txpreemph_o  = preemph_q;
  assign mgt_txpostemph_o = postemph_q;
  assign mgt_txdiffctrl_o = diffctrl_q;

endmodule

//--- logic/fabric_loopback.sv
`timescale 1ns/1ps
`include "gbe_defines.svh"

module fabric_loopback (
  input  logic       wb_clk_i,
  input  logic       wb_rst_i,
  input  logic [7:0] cpu_tx_size_i,
  input  logic       cpu_tx_ready_i,
  input  logic       cpu_rx_ack_i,
  output logic       cpu_tx_done_o,
  output logic [7:0] cpu_rx_size_o,
  cpu_mem_if.master  tx_fab,
  cpu_mem_if.master  rx_fab,
  cpu_mem_if.master  arp_fab
);

  localparam logic [1:0] ST_IDLE   = 2'd0;
  localparam logic [1:0] ST_LOOKUP = 2'd1;
  localparam logic [1:0] ST_COPY   = 2'd2;
  localparam logic [1:0] ST_FINISH = 2'd3;

  logic [1:0]             state_q;
  logic [`GBE_BUF_AW-1:0] rd_idx_q;
  logic [`GBE_BUF_AW-1:0] wr_idx_q;
  logic [`GBE_BUF_AW-1:0] last_idx;
  logic                   tx_done_q;
  logic [7:0]             rx_size_q;

  assign last_idx = cpu_tx_size_i - 8'd1;

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      state_q   <= ST_IDLE;
      rd_idx_q  <= '0;
      wr_idx_q  <= '0;
      tx_done_q <= 1'b0;
      rx_size_q <= 8'd0;
    end else begin
      tx_done_q <= 1'b0;
      if (cpu_rx_ack_i) begin
        rx_size_q <= 8'd0;
      end
      case (state_q)
        ST_IDLE: begin
          rd_idx_q <= '0;
          wr_idx_q <= '0;
          // hold off while the last rx frame is unacknowledged
          if (cpu_tx_ready_i && !tx_done_q && rx_size_q == 8'd0) begin
            state_q <= (cpu_tx_size_i == 8'd0) ? ST_FINISH : ST_LOOKUP;
          end
        end
        ST_LOOKUP: begin
          // word 0 is out, its low byte indexes the arp cache
          rd_idx_q <= 1;
          state_q  <= ST_COPY;
        end
        ST_COPY: begin
          rd_idx_q <= rd_idx_q + 1'b1;
          wr_idx_q <= wr_idx_q + 1'b1;
          if (wr_idx_q == last_idx) begin
            state_q <= ST_FINISH;
          end
        end
        default: begin
          tx_done_q <= 1'b1;
          rx_size_q <= cpu_tx_size_i;
          state_q   <= ST_IDLE;
        end
      endcase
    end
  end

  assign tx_fab.addr     = rd_idx_q;
  assign tx_fab.wr_data  = 64'd0;
  assign tx_fab.wr_en    = 1'b0;
  assign arp_fab.addr    = tx_fab.rd_data[7:0];
  assign arp_fab.wr_data = 48'd0;
  assign arp_fab.wr_en   = 1'b0;

  // next-hop mac replaces the top 48 bits of word 0
  assign rx_fab.addr    = wr_idx_q;
  assign rx_fab.wr_en   = (state_q == ST_COPY);
  assign rx_fab.wr_data = (wr_idx_q == '0) ? {arp_fab.rd_data, tx_fab.rd_data[15:0]}
                                           : tx_fab.rd_data;

  assign cpu_tx_done_o = tx_done_q;
  assign cpu_rx_size_o = rx_size_q;

endmodule

//--- logic/gbe_cpu_top.sv
`timescale 1ns/1ps
`include "gbe_defines.svh"

module gbe_cpu_top (
  input  logic        wb_clk_i,
  input  logic        wb_rst_i,
  input  logic [31:0] wb_adr_i,
  input  logic [31:0] wb_dat_i,
  input  logic [3:0]  wb_sel_i,
  input  logic        wb_we_i,
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  output logic [31:0] wb_dat_o,
  output logic        wb_ack_o,
  input  logic [7:0]  xaui_status_i,
  input  logic        soft_reset_ack_i,
  output logic        local_enable_o,
  output logic [47:0] local_mac_o,
  output logic [31:0] local_ip_o,
  output logic [15:0] local_port_o,
  output logic [7:0]  local_gateway_o,
  output logic [31:0] local_mc_ip_o,
  output logic [31:0] local_mc_mask_o,
  output logic        soft_reset_o,
  output logic [2:0]  mgt_rxeqmix_o,
  output logic [3:0]  mgt_txpreemph_o,
  output logic [4:0]  mgt_txpostemph_o,
  output logic [3:0]  mgt_txdiffctrl_o
);

  logic [7:0] cpu_tx_size;
  logic       cpu_tx_ready;
  logic       cpu_rx_ack;
  logic       cpu_tx_done;
  logic [7:0] cpu_rx_size;

  cpu_mem_if #(.DATA_W(64)) tx_cpu ();
  cpu_mem_if #(.DATA_W(64)) rx_cpu ();
  cpu_mem_if #(.DATA_W(48)) arp_cpu ();
  cpu_mem_if #(.DATA_W(64)) tx_fab ();
  cpu_mem_if #(.DATA_W(64)) rx_fab ();
  cpu_mem_if #(.DATA_W(48)) arp_fab ();

  dual_port_ram #(.DATA_W(64), .DEPTH(`GBE_BUF_DEPTH)) tx_ram_inst (
    .wb_clk_i,
    .a (tx_cpu.mem),
    .b (tx_fab.mem)
  );

  dual_port_ram #(.DATA_W(64), .DEPTH(`GBE_BUF_DEPTH)) rx_ram_inst (
    .wb_clk_i,
    .a (rx_cpu.mem),
    .b (rx_fab.mem)
  );

  dual_port_ram #(.DATA_W(48), .DEPTH(`GBE_BUF_DEPTH)) arp_ram_inst (
    .wb_clk_i,
    .a (arp_cpu.mem),
    .b (arp_fab.mem)
  );

  // remaining ports share their names with the top
  wb_attach wb_attach_inst (
    .tx_mem         (tx_cpu.master),
    .rx_mem         (rx_cpu.master),
    .arp_mem        (arp_cpu.master),
    .cpu_tx_size_o  (cpu_tx_size),
    .cpu_tx_ready_o (cpu_tx_ready),
    .cpu_rx_ack_o   (cpu_rx_ack),
    .cpu_tx_done_i  (cpu_tx_done),
    .cpu_rx_size_i  (cpu_rx_size),
    .*
  );

  fabric_loopback fabric_loopback_inst (
    .wb_clk_i,
    .wb_rst_i,
    .cpu_tx_size_i  (cpu_tx_size),
    .cpu_tx_ready_i (cpu_tx_ready),
    .cpu_rx_ack_i   (cpu_rx_ack),
    .cpu_tx_done_o  (cpu_tx_done),
    .cpu_rx_size_o  (cpu_rx_size),
    .tx_fab         (tx_fab.master),
    .rx_fab         (rx_fab.master),
    .arp_fab        (arp_fab.master)
  );

endmodule

//--- testbench/gbe_cpu_assert.sv
`timescale 1ns/1ps

module gbe_cpu_assert (
  input logic        wb_clk_i,
  input logic        wb_rst_i,
  input logic        we_i,
  input logic        ack_i,
  input logic [31:0] dat_i,
  input logic        reg_sel_i,
  input logic        rx_sel_i,
  input logic        tx_sel_i,
  input logic        arp_sel_i,
  input logic        tx_we_i,
  input logic        arp_we_i
);

  logic one_cycle;
  logic two_cycle;

  // strobes taken this cycle, split by ack latency
  assign one_cycle = reg_sel_i || rx_sel_i || ((tx_sel_i || arp_sel_i) && !we_i);
  assign two_cycle = (tx_sel_i || arp_sel_i) && we_i;

  a_ack_single: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    ack_i |=> !ack_i)
    else $error("ack held high for two cycles");

  a_ack_read: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    one_cycle |=> ack_i)
    else $error("ack missing one cycle after a register or read strobe");

  a_ack_write_gap: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    two_cycle |=> !ack_i)
    else $error("ack too early after a tx or arp write strobe");

  a_ack_write: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    $past(two_cycle, 2) |-> ack_i)
    else $error("ack missing two cycles after a tx or arp write strobe");

  a_ack_source: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    ack_i |-> ($past(one_cycle) || $past(two_cycle, 2)))
    else $error("ack without a matching strobe");

  a_dat_idle: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    !ack_i |-> (dat_i == 32'd0))
    else $error("read data nonzero while ack is low");

  a_wr_en: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    (tx_we_i || arp_we_i) |-> ack_i)
    else $error("memory write enable outside the ack cycle");

endmodule

bind wb_attach gbe_cpu_assert gbe_cpu_assert_inst (
  .wb_clk_i  (wb_clk_i),
  .wb_rst_i  (wb_rst_i),
  .we_i      (wb_we_i),
  .ack_i     (wb_ack_o),
  .dat_i     (wb_dat_o),
  .reg_sel_i (reg_sel),
  .rx_sel_i  (rx_sel),
  .tx_sel_i  (tx_sel),
  .arp_sel_i (arp_sel),
  .tx_we_i   (tx_we_q),
  .arp_we_i  (arp_we_q)
);

//--- testbench/gbe_cpu_tb.sv
`timescale 1ns/1ps
`include "gbe_defines.svh"

module gbe_cpu_tb;
  import gbe_pkg::*;

  localparam int TIMEOUT_CYCLES = 4000;
  localparam logic [3:0] LANE_REGS [7] = '{`GBE_REG_MAC_HI, `GBE_REG_MAC_LO,
    `GBE_REG_GATEWAY, `GBE_REG_IP, `GBE_REG_MC_IP, `GBE_REG_MC_MASK, `GBE_REG_PHY};

  logic        wb_clk_i;
  logic        wb_rst_i;
  logic [31:0] wb_adr_i;
  logic [31:0] wb_dat_i;
  logic [3:0]  wb_sel_i;
  logic        wb_we_i;
  logic        wb_cyc_i;
  logic        wb_stb_i;
  logic [31:0] wb_dat_o;
  logic        wb_ack_o;
  logic [7:0]  xaui_status_i;
  logic        soft_reset_ack_i;
  logic        local_enable_o;
  logic [47:0] local_mac_o;
  logic [31:0] local_ip_o;
  logic [15:0] local_port_o;
  logic [7:0]  local_gateway_o;
  logic [31:0] local_mc_ip_o;
  logic [31:0] local_mc_mask_o;
  logic        soft_reset_o;
  logic [2:0]  mgt_rxeqmix_o;
  logic [3:0]  mgt_txpreemph_o;
  logic [4:0]  mgt_txpostemph_o;
  logic [3:0]  mgt_txdiffctrl_o;

  int          seed = 87617;
  int          cycle_cnt = 0;
  logic [47:0] mac_m;
  logic [31:0] ip_m;
  logic [31:0] mc_ip_m;
  logic [31:0] mc_mask_m;
  logic [7:0]  gw_m;
  reg_word_u   phy_m;
  logic [63:0] tx_m [256];
  logic [47:0] arp_m [256];

  gbe_cpu_top gbe_cpu_top_inst (.*);

  initial begin
    wb_clk_i = 1'b0;
    forever #20 wb_clk_i = ~wb_clk_i;
  end

  always @(posedge wb_clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: test still running after %0d cycles", TIMEOUT_CYCLES);
      $display("Test FAILED");
      $fatal(1, "simulation timeout");
    end
  end

  function automatic logic [31:0] next_rand();
    return $random(seed);
  endfunction

  function automatic logic [31:0] reg_addr(input logic [3:0] idx);
    return `GBE_REG_BASE + {26'd0, idx, 2'b00};
  endfunction

  // bit 2 of a buffer address picks the low half of the 64-bit word
  function automatic logic [31:0] buf_addr(input logic [31:0] base, input logic [7:0] idx,
                                           input logic lo);
    return base + {21'd0, idx, lo, 2'b00};
  endfunction

  function automatic logic [31:0] byte_update(input logic [31:0] old_w, input logic [31:0] new_w,
                                              input logic [3:0] sel);
    logic [31:0] mask;
    mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
    return (old_w & ~mask) | (new_w & mask);
  endfunction

  function automatic logic [31:0] model_reg(input logic [3:0] idx);
    case (idx)
      `GBE_REG_MAC_HI:  return {16'd0, mac_m[47:32]};
      `GBE_REG_MAC_LO:  return mac_m[31:0];
      `GBE_REG_GATEWAY: return {24'd0, gw_m};
      `GBE_REG_IP:      return ip_m;
      `GBE_REG_MC_IP:   return mc_ip_m;
      `GBE_REG_MC_MASK: return mc_mask_m;
      default:          return phy_m.raw;
    endcase
  endfunction

  task automatic set_model_reg(input logic [3:0] idx, input logic [31:0] val);
    case (idx)
      `GBE_REG_MAC_HI:  mac_m[47:32] = val[15:0];
      `GBE_REG_MAC_LO:  mac_m[31:0] = val;
      `GBE_REG_GATEWAY: gw_m = val[7:0];
      `GBE_REG_IP:      ip_m = val;
      `GBE_REG_MC_IP:   mc_ip_m = val;
      `GBE_REG_MC_MASK: mc_mask_m = val;
      // only the phy fields exist, reserved bits read zero
      default:          phy_m.raw = val & 32'h0f0f_1f07;
    endcase
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("Mismatch %s: expected %08h, actual %08h", name, expected, actual);
      $display("Test FAILED");
      $fatal(1, "check %s failed", name);
    end
  endtask

  task automatic wait_ack();
    do begin
      @(posedge wb_clk_i);
    end while (wb_ack_o !== 1'b1);
  endtask

  task automatic bus_write(input logic [31:0] adr, input logic [31:0] dat, input logic [3:0] sel);
    @(posedge wb_clk_i);
    wb_adr_i <= adr;
    wb_dat_i <= dat;
    wb_sel_i <= sel;
    wb_we_i  <= 1'b1;
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    wait_ack();
    wb_we_i  <= 1'b0;
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
  endtask

  task automatic bus_read(input logic [31:0] adr, output logic [31:0] dat);
    @(posedge wb_clk_i);
    wb_adr_i <= adr;
    wb_sel_i <= 4'hf;
    wb_we_i  <= 1'b0;
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    wait_ack();
    dat = wb_dat_o;
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
  endtask

  task automatic read_expect(input string name, input logic [31:0] adr,
                             input logic [31:0] expected);
    logic [31:0] rd;
    bus_read(adr, rd);
    check_value(name, expected, rd);
  endtask

  task automatic check_outputs(input string name);
    check_value({name, " mac hi"}, {16'd0, mac_m[47:32]}, {16'd0, local_mac_o[47:32]});
    check_value({name, " mac lo"}, mac_m[31:0], local_mac_o[31:0]);
    check_value({name, " ip"}, ip_m, local_ip_o);
    check_value({name, " gateway"}, {24'd0, gw_m}, {24'd0, local_gateway_o});
    check_value({name, " mc ip"}, mc_ip_m, local_mc_ip_o);
    check_value({name, " mc mask"}, mc_mask_m, local_mc_mask_o);
    // ports register is never written through its port or enable lanes
    check_value({name, " port"}, {16'd0, `GBE_DEF_PORT}, {16'd0, local_port_o});
    check_value({name, " enable"}, {31'd0, `GBE_DEF_ENABLE}, {31'd0, local_enable_o});
    check_value({name, " phy"}, phy_m.raw, {4'd0, mgt_txdiffctrl_o, 4'd0, mgt_txpreemph_o,
                                            3'd0, mgt_txpostemph_o, 5'd0, mgt_rxeqmix_o});
  endtask

  task automatic write_tx_word(input logic [7:0] idx, input logic [63:0] data);
    bus_write(buf_addr(`GBE_TXBUF_BASE, idx, 1'b0), data[63:32], 4'hf);
    bus_write(buf_addr(`GBE_TXBUF_BASE, idx, 1'b1), data[31:0], 4'hf);
    tx_m[idx] = data;
  endtask

  task automatic write_arp_entry(input logic [7:0] idx, input logic [47:0] mac);
    bus_write(buf_addr(`GBE_ARP_BASE, idx, 1'b0), {16'd0, mac[47:32]}, 4'hf);
    bus_write(buf_addr(`GBE_ARP_BASE, idx, 1'b1), mac[31:0], 4'hf);
    arp_m[idx] = mac;
  endtask

  task automatic test_reset_defaults();
    reg_word_u w;
    mac_m = `GBE_DEF_MAC;
    ip_m = `GBE_DEF_IP;
    gw_m = `GBE_DEF_GATEWAY;
    mc_ip_m = `GBE_DEF_MC_IP;
    mc_mask_m = `GBE_DEF_MC_MASK;
    phy_m.raw = '0;
    phy_m.phy.rxeqmix = `GBE_DEF_RXEQMIX;
    phy_m.phy.postemph = `GBE_DEF_POSTEMPH;
    phy_m.phy.preemph = `GBE_DEF_PREEMPH;
    phy_m.phy.diffctrl = `GBE_DEF_DIFFCTRL;
    read_expect("reset MAC_HI", reg_addr(`GBE_REG_MAC_HI), {16'd0, mac_m[47:32]});
    read_expect("reset MAC_LO", reg_addr(`GBE_REG_MAC_LO), mac_m[31:0]);
    read_expect("reset GATEWAY", reg_addr(`GBE_REG_GATEWAY), {24'd0, gw_m});
    read_expect("reset IP", reg_addr(`GBE_REG_IP), ip_m);
    read_expect("reset SIZES", reg_addr(`GBE_REG_SIZES), 32'd0);
    w.raw = '0;
    w.ports.enable = `GBE_DEF_ENABLE;
    w.ports.port = `GBE_DEF_PORT;
    read_expect("reset PORTS", reg_addr(`GBE_REG_PORTS), w.raw);
    read_expect("reset XAUI_STATUS", reg_addr(`GBE_REG_XAUI_STATUS), {24'd0, xaui_status_i});
    read_expect("reset PHY", reg_addr(`GBE_REG_PHY), phy_m.raw);
    read_expect("reset MC_IP", reg_addr(`GBE_REG_MC_IP), mc_ip_m);
    read_expect("reset MC_MASK", reg_addr(`GBE_REG_MC_MASK), mc_mask_m);
    check_outputs("reset outputs");
  endtask

  task automatic test_reg_lanes();
    logic [31:0] rnd;
    logic [31:0] dat;
    logic [3:0]  idx;
    for (int n = 0; n < 16; n++) begin
      rnd = next_rand();
      dat = next_rand();
      idx = LANE_REGS[int'(rnd[15:0] % 16'd7)];
      bus_write(reg_addr(idx), dat, rnd[19:16]);
      set_model_reg(idx, byte_update(model_reg(idx), dat, rnd[19:16]));
      read_expect("register lanes", reg_addr(idx), model_reg(idx));
      check_outputs("register lanes");
    end
  endtask

  task automatic test_buffer_rmw();
    logic [31:0] hi;
    logic [31:0] lo;
    logic [31:0] rnd;
    logic [7:0]  idx;
    for (int n = 0; n < 4; n++) begin
      rnd = next_rand();
      idx = rnd[7:0];
      hi = next_rand();
      lo = next_rand();
      write_tx_word(idx, {hi, lo});
      write_arp_entry(idx, {hi[15:0], lo});
      // partial selects merge into the half picked by address bit 2
      hi = next_rand();
      lo = next_rand();
      bus_write(buf_addr(`GBE_TXBUF_BASE, idx, 1'b0), hi, rnd[11:8]);
      bus_write(buf_addr(`GBE_TXBUF_BASE, idx, 1'b1), lo, rnd[15:12]);
      tx_m[idx] = {byte_update(tx_m[idx][63:32], hi, rnd[11:8]),
                   byte_update(tx_m[idx][31:0], lo, rnd[15:12])};
      read_expect("tx rmw high", buf_addr(`GBE_TXBUF_BASE, idx, 1'b0), tx_m[idx][63:32]);
      read_expect("tx rmw low", buf_addr(`GBE_TXBUF_BASE, idx, 1'b1), tx_m[idx][31:0]);
      bus_write(buf_addr(`GBE_ARP_BASE, idx, rnd[16]), hi, 4'hf);
      if (rnd[16]) begin
        arp_m[idx][31:0] = hi;
      end else begin
        arp_m[idx][47:32] = hi[15:0];
      end
      read_expect("arp rmw high", buf_addr(`GBE_ARP_BASE, idx, 1'b0), {16'd0, arp_m[idx][47:32]});
      read_expect("arp rmw low", buf_addr(`GBE_ARP_BASE, idx, 1'b1), arp_m[idx][31:0]);
    end
  endtask

  task automatic load_frame(input int nwords);
    logic [31:0] hi;
    logic [31:0] lo;
    for (int n = 0; n < nwords; n++) begin
      hi = next_rand();
      lo = next_rand();
      write_tx_word(8'(n), {hi, lo});
    end
    hi = next_rand();
    lo = next_rand();
    write_arp_entry(tx_m[0][7:0], {hi[15:0], lo});
  endtask

  task automatic submit_frame(input logic [7:0] size);
    reg_word_u w;
    w.raw = '0;
    w.sizes.tx_size = size;
    bus_write(reg_addr(`GBE_REG_SIZES), w.raw, 4'b0100);
  endtask

  task automatic wait_tx_done();
    logic [31:0] rd;
    reg_word_u   w;
    do begin
      bus_read(reg_addr(`GBE_REG_SIZES), rd);
      w.raw = rd;
    end while (w.sizes.tx_size != 8'd0);
  endtask

  task automatic check_rx_frame(input string name, input int nwords);
    logic [63:0] exp_w;
    for (int n = 0; n < nwords; n++) begin
      // word 0 carries the next-hop mac from the arp cache
      exp_w = (n == 0) ? {arp_m[tx_m[0][7:0]], tx_m[0][15:0]} : tx_m[n];
      read_expect(name, buf_addr(`GBE_RXBUF_BASE, 8'(n), 1'b0), exp_w[63:32]);
      read_expect(name, buf_addr(`GBE_RXBUF_BASE, 8'(n), 1'b1), exp_w[31:0]);
    end
  endtask

  task automatic test_loopback();
    reg_word_u w;
    load_frame(4);
    submit_frame(8'd4);
    wait_tx_done();
    w.raw = '0;
    w.sizes.rx_size = 8'd4;
    read_expect("loopback sizes", reg_addr(`GBE_REG_SIZES), w.raw);
    check_rx_frame("loopback rx data", 4);
  endtask

  task automatic test_backpressure();
    logic [31:0] rd;
    reg_word_u   w;
    load_frame(2);
    submit_frame(8'd2);
    w.raw = '0;
    w.sizes.tx_size = 8'd2;
    w.sizes.rx_size = 8'd4;
    for (int n = 0; n < 3; n++) begin
      read_expect("backpressure sizes", reg_addr(`GBE_REG_SIZES), w.raw);
    end
    bus_write(reg_addr(`GBE_REG_SIZES), 32'd0, 4'b0001);
    bus_read(reg_addr(`GBE_REG_SIZES), rd);
    w.raw = rd;
    check_value("rx ack size", 32'd0, {24'd0, w.sizes.rx_size});
    wait_tx_done();
    w.raw = '0;
    w.sizes.rx_size = 8'd2;
    read_expect("second frame sizes", reg_addr(`GBE_REG_SIZES), w.raw);
    check_rx_frame("second frame rx data", 2);
  endtask

  task automatic test_soft_reset();
    reg_word_u w;
    w.raw = '0;
    w.ports.soft_reset = 1'b1;
    bus_write(reg_addr(`GBE_REG_PORTS), w.raw, 4'b1000);
    check_value("soft reset raised", 32'd1, {31'd0, soft_reset_o});
    w.ports.enable = `GBE_DEF_ENABLE;
    w.ports.port = `GBE_DEF_PORT;
    read_expect("soft reset read", reg_addr(`GBE_REG_PORTS), w.raw);
    @(posedge wb_clk_i);
    soft_reset_ack_i <= 1'b1;
    @(posedge wb_clk_i);
    soft_reset_ack_i <= 1'b0;
    @(posedge wb_clk_i);
    check_value("soft reset cleared", 32'd0, {31'd0, soft_reset_o});
    w.ports.soft_reset = 1'b0;
    read_expect("soft reset cleared read", reg_addr(`GBE_REG_PORTS), w.raw);
    check_outputs("soft reset outputs");
  endtask

  initial begin
    logic [31:0] rnd;
    rnd = next_rand();
    wb_rst_i = 1'b1;
    wb_adr_i = 32'd0;
    wb_dat_i = 32'd0;
    wb_sel_i = 4'd0;
    wb_we_i = 1'b0;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    xaui_status_i = rnd[7:0];
    soft_reset_ack_i = 1'b0;
    repeat (2) @(posedge wb_clk_i);
    wb_rst_i <= 1'b0;
    test_reset_defaults();
    test_reg_lanes();
    test_buffer_rmw();
    test_loopback();
    test_backpressure();
    test_soft_reset();
    $display("Test OK");
    $finish;
  end

endmodule

//--- gbe_cpu_top.f
+incdir+logic
logic/gbe_pkg.sv
logic/cpu_mem_if.sv
logic/dual_port_ram.sv
logic/wb_attach.sv
logic/fabric_loopback.sv
logic/gbe_cpu_top.sv
testbench/gbe_cpu_assert.sv
testbench/gbe_cpu_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the gbe_cpu testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert -j 0 \
  -f gbe_cpu_top.f \
  --top-module gbe_cpu_tb \
  -o gbe_cpu_sim

./obj_dir/gbe_cpu_sim
